/* Makefile */
VERILATOR ?= verilator
TOP       ?= maxSearchTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
+incdir+include
design/metricPkg.sv
design/groupDecode.sv
design/compSel.sv
design/maxAccum.sv
design/maxSearchTop.sv
verification/maxSearchTb.sv

/* design/compSel.sv */
`timescale 1ns/10ps

// four-way signed compare-select, one group per ce
module compSel (
   input  logic               clk,
   input  logic               reset,
   input  logic               ce,
   input  metricPkg::metric_t a,
   input  metricPkg::metric_t b,
   input  metricPkg::metric_t c,
   input  metricPkg::metric_t d,
   input  metricPkg::index_t  indexOffset,
   output metricPkg::metric_t groupMax,
   output metricPkg::index_t  groupIndex
);
   import metricPkg::*;

   logic    sel0;         // b beats a
   logic    sel1;         // d beats c
   logic    selFinal;     // c/d pair beats a/b pair
   metric_t winner0;
   metric_t winner1;
   metric_t bestVal;
   logic [1:0] localIndex;

   // 1 only when second is strictly larger, so ties stay with the earlier input
   function automatic logic laterWins(input metric_t first, input metric_t second);
      logic result;
      case ({first[metricWidth-1], second[metricWidth-1]})
         2'b01: begin
            result = 1'b0;   // first pos, second neg
         end
         2'b10: begin
            result = 1'b1;   // first neg, second pos
         end
         default: begin
            // same sign, magnitude bits order the same way
            result = (second[metricWidth-2:0] > first[metricWidth-2:0]);
         end
      endcase
      return result;
   endfunction

   // first round, pairwise
   assign sel0 = laterWins(a, b);
   assign sel1 = laterWins(c, d);

   assign winner0 = sel0 ? b : a;
   assign winner1 = sel1 ? d : c;

   // second round between pair winners
   assign selFinal = laterWins(winner0, winner1);
   assign bestVal  = selFinal ? winner1 : winner0;

   // position inside the group, a=0 .. d=3
   assign localIndex = selFinal ? {1'b1, sel1} : {1'b0, sel0};

   always_ff @(posedge clk) begin
      if (reset) begin
         groupMax   <= '0;
         groupIndex <= '0;
      end else if (ce) begin
         groupMax   <= bestVal;
         groupIndex <= indexOffset + index_t'(localIndex);   // block-wide index
      end
   end

   // the offset from groupDecode must leave room for the local position
   offsetAligned : assert property (
      @(posedge clk) disable iff (reset)
      ce |-> (indexOffset[1:0] == 2'b00)
   ) else $error("indexOffset not group aligned");

endmodule

/* design/groupDecode.sv */
`timescale 1ns/10ps

module groupDecode (
   input  logic              clk,
   input  logic              reset,
   input  logic              metricValid,
   input  logic              normalize,
   output logic              selCe,
   output metricPkg::index_t indexOffset,
   output logic              groupValid,
   output logic              groupFirst,
   output logic              groupLast,
   output logic              groupNorm
);
   import metricPkg::*;

   logic [groupWidth-1:0] groupCount;   // group number inside the block
   logic                  firstNow;
   logic                  lastNow;

   // compSel loads on every valid group
   assign selCe = metricValid;

   // group g holds candidates 4g..4g+3
   assign indexOffset = {groupCount, 2'b00};

   assign firstNow = (groupCount == '0);
   assign lastNow  = (groupCount == groupWidth'(groupsPerBlock - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         groupCount <= '0;
      end else if (metricValid) begin
         if (lastNow) begin
            groupCount <= '0;   // wrap for next block
         end else begin
            groupCount <= groupCount + 1'b1;
         end
      end
   end

   // flags ride one cycle behind beside the compSel result
   always_ff @(posedge clk) begin
      if (reset) begin
         groupValid <= 1'b0;
         groupFirst <= 1'b0;
         groupLast  <= 1'b0;
      end else begin
         groupValid <= metricValid;
         groupFirst <= metricValid & firstNow;
         groupLast  <= metricValid & lastNow;
      end
   end

   // only meaningful with the last group
   always_ff @(posedge clk) begin
      if (metricValid) begin
         groupNorm <= normalize;
      end
   end

   // a group right after a last group opens the next block
   lastThenFirst : assert property (
      @(posedge clk) disable iff (reset)
      groupLast |=> (!groupValid || groupFirst)
   ) else $error("group after the last group not marked first");

endmodule

/* design/maxAccum.sv */
`timescale 1ns/10ps

module maxAccum (
   input  logic               clk,
   input  logic               reset,
   input  logic               groupValid,
   input  logic               groupFirst,
   input  logic               groupLast,
   input  logic               groupNorm,
   input  metricPkg::metric_t groupMax,
   input  metricPkg::index_t  groupIndex,
   output logic               done,
   output metricPkg::metric_t maxVal,
   output metricPkg::index_t  maxIndex
);
   import metricPkg::*;

   metric_t runMax;        // best value so far in this block
   index_t  runIndex;
   logic    takeGroup;
   metric_t blockMax;      // best including the current group
   index_t  blockIndex;
   metric_t normVal;

   // strictly greater, a tie keeps the lower index already held
   assign takeGroup = groupFirst | (groupMax > runMax);

   assign blockMax   = takeGroup ? groupMax : runMax;
   assign blockIndex = takeGroup ? groupIndex : runIndex;

   // wraps in 8 bits like the hardware subtract
   assign normVal = metric_t'(blockMax - metric_t'(normOffset));

   always_ff @(posedge clk) begin
      if (groupValid) begin
         runMax   <= blockMax;
         runIndex <= blockIndex;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         done     <= 1'b0;
         maxVal   <= '0;
         maxIndex <= '0;
      end else begin
         done <= 1'b0;
         if (groupValid && groupLast) begin
            done     <= 1'b1;
            maxVal   <= groupNorm ? normVal : blockMax;
            maxIndex <= blockIndex;   // held until next block ends
         end
      end
   end

   // blocks are 16 groups, so two done pulses can never touch
   doneIsPulse : assert property (
      @(posedge clk) disable iff (reset)
      done |=> !done
   ) else $error("done high on two consecutive cycles");

endmodule

/* design/maxSearchTop.sv */
`timescale 1ns/10ps

module maxSearchTop (
   input  logic               clk,
   input  logic               reset,
   input  logic               metricValid,
   input  logic               normalize,
   input  metricPkg::metric_t a,
   input  metricPkg::metric_t b,
   input  metricPkg::metric_t c,
   input  metricPkg::metric_t d,
   output logic               done,
   output metricPkg::metric_t maxVal,
   output metricPkg::index_t  maxIndex
);
   import metricPkg::*;

   logic    selCe;
   index_t  indexOffset;
   logic    groupValid;
   logic    groupFirst;
   logic    groupLast;
   logic    groupNorm;
   metric_t groupMax;
   index_t  groupIndex;

   // decode stage
   groupDecode groupDecode_inst (
      .clk         (clk),
      .reset       (reset),
      .metricValid (metricValid),
      .normalize   (normalize),
      .selCe       (selCe),
      .indexOffset (indexOffset),
      .groupValid  (groupValid),
      .groupFirst  (groupFirst),
      .groupLast   (groupLast),
      .groupNorm   (groupNorm)
   );

   // execute stage
   compSel compSel_inst (
      .clk         (clk),
      .reset       (reset),
      .ce          (selCe),
      .a           (a),
      .b           (b),
      .c           (c),
      .d           (d),
      .indexOffset (indexOffset),
      .groupMax    (groupMax),
      .groupIndex  (groupIndex)
   );

   // result stage
   maxAccum maxAccum_inst (
      .clk        (clk),
      .reset      (reset),
      .groupValid (groupValid),
      .groupFirst (groupFirst),
      .groupLast  (groupLast),
      .groupNorm  (groupNorm),
      .groupMax   (groupMax),
      .groupIndex (groupIndex),
      .done       (done),
      .maxVal     (maxVal),
      .maxIndex   (maxIndex)
   );

endmodule

/* design/metricPkg.sv */
package metricPkg;

   // one signed metric per candidate
   localparam int metricWidth = 8;
   typedef logic signed [metricWidth-1:0] metric_t;

   // candidate index covers 0..63 in multi H mode
   localparam int indexWidth = 6;
   typedef logic [indexWidth-1:0] index_t;

   // a block is 16 groups of four metrics
   localparam int groupsPerBlock = 16;
   localparam int groupWidth = $clog2(groupsPerBlock);   // 4 bits

   // normalization subtracts a quarter of the full range
   localparam int normOffset = 2**(metricWidth-2);      // 64

endpackage

/* include/maxSearchChecks.svh */
`ifndef MAX_SEARCH_CHECKS_SVH
`define MAX_SEARCH_CHECKS_SVH

// strict signed compare of two metrics
function automatic bit signedGreater(
   input metricPkg::metric_t x,
   input metricPkg::metric_t y
);
   return (x > y);
endfunction

// expected block result with ties going to the lowest index
function automatic void refMax(
   input  metricPkg::metric_t vals [2**metricPkg::indexWidth],
   input  bit                 norm,
   output metricPkg::metric_t expVal,
   output metricPkg::index_t  expIndex
);
   metricPkg::metric_t best;
   metricPkg::index_t  bestIndex;
   best      = vals[0];
   bestIndex = '0;
   for (int i = 1; i < 2**metricPkg::indexWidth; i++) begin
      if (signedGreater(vals[i], best)) begin
         best      = vals[i];
         bestIndex = metricPkg::index_t'(i);
      end
   end
   // subtract a quarter of the range and keep the low 8 bits
   if (norm) begin
      best = metricPkg::metric_t'(int'(best) - metricPkg::normOffset);
   end
   expVal   = best;
   expIndex = bestIndex;
endfunction

// metric check that bumps the caller's counter on mismatch
task automatic compareMetric(
   input string              name,
   input metricPkg::metric_t expected,
   input metricPkg::metric_t actual,
   inout int                 errorCount
);
   if (actual !== expected) begin
      $display("ERROR: %0t %s expected %0d actual %0d", $time, name, expected, actual);
      errorCount++;
   end
endtask

// index check
task automatic compareIndex(
   input string             name,
   input metricPkg::index_t expected,
   input metricPkg::index_t actual,
   inout int                errorCount
);
   if (actual !== expected) begin
      $display("ERROR: %0t %s expected %0d actual %0d", $time, name, expected, actual);
      errorCount++;
   end
endtask

`endif

/* verification/maxSearchTb.sv */
`timescale 1ns/10ps

module maxSearchTb;
   import metricPkg::*;

   `include "maxSearchChecks.svh"

   localparam int blockSize = 2**indexWidth;
   localparam int timeoutCycles = 8 * groupsPerBlock * 3 + 100;   // 484
   localparam int doneLatency = 3;   // drive edge to the edge that sees done

   logic    clk;
   logic    reset;
   logic    metricValid;
   logic    normalize;
   metric_t a;
   metric_t b;
   metric_t c;
   metric_t d;
   logic    done;
   metric_t maxVal;
   index_t  maxIndex;

   int        cycle = 0;
   bit [31:0] lcgState = 32'hb0f0;
   metric_t   blockVals [blockSize];
   int        valueErrors = 0;
   int        indexErrors = 0;
   int        timingErrors = 0;
   int        protocolErrors = 0;

   // expected results with one entry per block in flight
   metric_t expValQ [$];
   index_t  expIdxQ [$];
   int      expCycleQ [$];

   maxSearchTop maxSearchTop_inst (
      .clk         (clk),
      .reset       (reset),
      .metricValid (metricValid),
      .normalize   (normalize),
      .a           (a),
      .b           (b),
      .c           (c),
      .d           (d),
      .done        (done),
      .maxVal      (maxVal),
      .maxIndex    (maxIndex)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   function automatic bit [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   task automatic compareDoneCycle(input int expected, input int actual);
      if (actual != expected) begin
         $display("ERROR: %0t done cycle expected %0d actual %0d", $time, expected, actual);
         timingErrors++;
      end
   endtask

   task automatic fillRandom();
      bit [31:0] r;
      for (int i = 0; i < blockSize; i++) begin
         r = nextRand();
         blockVals[i] = metric_t'(r[23:16]);
      end
   endtask

   task automatic fillConstant(input metric_t value);
      for (int i = 0; i < blockSize; i++) begin
         blockVals[i] = value;
      end
   endtask

   // peak repeated in later groups where 40 is the lowest copy
   task automatic fillRepeatedMax();
      bit [31:0] r;
      for (int i = 0; i < blockSize; i++) begin
         r = nextRand();
         blockVals[i] = metric_t'(int'(r % 200) - 100);   // -100..99
      end
      blockVals[40] = metric_t'(110);
      blockVals[45] = metric_t'(110);
      blockVals[61] = metric_t'(110);
   endtask

   task automatic fillSingle(input int peakIndex, input metric_t peak, input metric_t background);
      fillConstant(background);
      blockVals[peakIndex] = peak;
   endtask

   // valid low with data and normalize scrambled for the DUT to ignore
   task automatic idleCycle();
      bit [31:0] r;
      r = nextRand();
      @(posedge clk);
      metricValid <= 1'b0;
      a           <= metric_t'(r[31:24]);
      b           <= metric_t'(r[23:16]);
      c           <= metric_t'(r[15:8]);
      d           <= metric_t'(r[7:0]);
      normalize   <= r[5];
   endtask

   // only the last group's normalize counts
   task automatic sendGroup(input int g, input bit norm, input bit lastGroup);
      bit [31:0] r;
      r = nextRand();
      @(posedge clk);
      metricValid <= 1'b1;
      a           <= blockVals[4*g];
      b           <= blockVals[4*g+1];
      c           <= blockVals[4*g+2];
      d           <= blockVals[4*g+3];
      normalize   <= lastGroup ? norm : r[12];
   endtask

   task automatic sendBlock(input bit norm, input bit gaps);
      metric_t   expV;
      index_t    expI;
      bit [31:0] r;
      int        gapLen;
      refMax(blockVals, norm, expV, expI);
      for (int g = 0; g < groupsPerBlock; g++) begin
         if (gaps) begin
            r = nextRand();
            gapLen = int'(r % 3);
            repeat (gapLen) idleCycle();
         end
         sendGroup(g, norm, g == groupsPerBlock - 1);
      end
      // still on the edge that drove the last group
      expValQ.push_back(expV);
      expIdxQ.push_back(expI);
      expCycleQ.push_back(cycle + doneLatency);
   endtask

   always @(posedge clk) begin : scoreboard
      metric_t expV;
      index_t  expI;
      int      expC;
      if (done) begin
         if (expValQ.size() == 0) begin
            $display("done pulse at %0t with no block outstanding", $time);
            protocolErrors++;
         end else begin
            expV = expValQ.pop_front();
            expI = expIdxQ.pop_front();
            expC = expCycleQ.pop_front();
            compareMetric("maxVal", expV, maxVal, valueErrors);
            compareIndex("maxIndex", expI, maxIndex, indexErrors);
            compareDoneCycle(expC, cycle);
         end
      end
   end

   initial begin : watchdog
      while (cycle < timeoutCycles) begin
         @(posedge clk);
      end
      $display("timeout after %0d cycles with %0d block results pending", cycle, expValQ.size());
      $display("errors: maxVal %0d maxIndex %0d timing %0d protocol %0d",
               valueErrors, indexErrors, timingErrors, protocolErrors + 1);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin : stimulus
      int totalErrors;
      reset       = 1'b1;
      metricValid = 1'b0;
      normalize   = 1'b0;
      a           = '0;
      b           = '0;
      c           = '0;
      d           = '0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // back to back blocks
      fillRandom();
      sendBlock(1'b0, 1'b0);
      fillConstant(metric_t'(-37));   // all equal negative so index 0
      sendBlock(1'b0, 1'b0);
      fillRepeatedMax();
      sendBlock(1'b0, 1'b0);
      fillRandom();
      sendBlock(1'b1, 1'b0);          // normalized
      fillSingle(17, metric_t'(-70), metric_t'(-128));
      sendBlock(1'b1, 1'b0);          // normalize wraps past -128
      fillSingle(63, metric_t'(127), metric_t'(-128));
      sendBlock(1'b0, 1'b0);
      fillConstant(metric_t'(-128));
      sendBlock(1'b0, 1'b0);

      // gaps inside and between blocks
      idleCycle();
      fillRandom();
      sendBlock(1'b1, 1'b1);

      // partial block cut off by reset produces no done
      fillRandom();
      for (int g = 0; g < 7; g++) begin
         sendGroup(g, 1'b0, 1'b0);
      end
      @(posedge clk);
      reset       <= 1'b1;
      metricValid <= 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      fillRandom();
      sendBlock(1'b0, 1'b1);
      idleCycle();

      // wait for the outstanding done pulses
      for (int i = 0; i < 20 && expValQ.size() > 0; i++) begin
         @(posedge clk);
      end
      if (expValQ.size() != 0) begin
         $display("%0d block results never arrived", expValQ.size());
         protocolErrors += expValQ.size();
      end
      totalErrors = valueErrors + indexErrors + timingErrors + protocolErrors;
      $display("errors: maxVal %0d maxIndex %0d timing %0d protocol %0d",
               valueErrors, indexErrors, timingErrors, protocolErrors);
      if (totalErrors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
